/* list.f */
+incdir+logic
logic/regdisp_pkg.sv
logic/regdisp_pipe_slice.sv
logic/regdisp_disp_map.sv
logic/regslv_slv_map.sv
logic/regdisp_top.sv
bench/regdisp_chk.sv
bench/regdisp_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINTFLAGS  ?= --lint-only --timing
TOP        ?= regdisp_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/regdisp_tb.sv */
`include "regdisp_params.svh"

module regdisp_tb
    import regdisp_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int DRIVE_DLY      = 1;
    localparam int NUM_TESTS      = 6;
    localparam int TEST_BUDGET_NS = 200;
    localparam int WATCHDOG_NS    = NUM_TESTS * TEST_BUDGET_NS + RESET_CYCLES * CLK_PERIOD;
    localparam int ACK_WAIT       = 8;
    // each enabled slice adds one cycle, the slave and the dummy one each
    localparam int LAT_MAPPED     = 1 + `REGDISP_FWD_FF + `REGDISP_BWD_FF;
    localparam int LAT_DUMMY      = 1 + `REGDISP_BWD_FF;

    logic           regdisp_disp_map_clk;
    logic           regdisp_disp_map_rst_n;
    logic           req_vld;
    addr_t          addr;
    logic           wr_en;
    logic           rd_en;
    data_t          wr_data;
    logic           non_sec;
    logic           soft_rst;
    logic           ack_vld;
    logic           err;
    data_t          rd_data;

    logic [31:0]    lcg_state;
    string          cur_test;
    int             check_fails;
    int             test_fails;
    int             fails_at_start;

    regdisp_top regdisp_top_inst (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .req_vld                (req_vld),
        .addr                   (addr),
        .wr_en                  (wr_en),
        .rd_en                  (rd_en),
        .wr_data                (wr_data),
        .non_sec                (non_sec),
        .soft_rst               (soft_rst),
        .ack_vld                (ack_vld),
        .err                    (err),
        .rd_data                (rd_data)
    );

    always #(CLK_PERIOD / 2) regdisp_disp_map_clk = ~regdisp_disp_map_clk;

    function automatic data_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // absolute bus address of a slave offset inside the window
    function automatic addr_t win_addr(input ofs_t ofs);
        return `REGDISP_BASE_ADDR + addr_t'(ofs);
    endfunction

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h got %h", cur_test, what, exp, act);
            check_fails++;
        end
    endtask

    task automatic check_err(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: %s err expected %b got %b", cur_test, what, exp, act);
            check_fails++;
        end
    endtask

    task automatic check_latency(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s: %s ack latency expected %0d got %0d", cur_test, what, exp, act);
            check_fails++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        fails_at_start = check_fails;
    endtask

    task automatic end_test();
        if (check_fails == fails_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            test_fails++;
            $display("test %s: %0d check(s) failed", cur_test, check_fails - fails_at_start);
        end
    endtask

    // one request, then wait for its ack and count the cycles in between
    task automatic bus_access(input addr_t a, input logic is_wr, input data_t wd,
                              input logic ns, input int exp_lat,
                              output logic got_err, output data_t got_data);
        int     n;
        logic   seen;
        n        = 0;
        seen     = 1'b0;
        got_err  = 1'b0;
        got_data = '0;
        @(posedge regdisp_disp_map_clk);
        #(DRIVE_DLY);
        req_vld = 1'b1;
        addr    = a;
        wr_en   = is_wr;
        rd_en   = !is_wr;
        wr_data = wd;
        non_sec = ns;
        while (!seen && n < ACK_WAIT) begin
            @(posedge regdisp_disp_map_clk);
            #(DRIVE_DLY);
            n++;
            if (n == 1) begin
                req_vld = 1'b0;
                wr_en   = 1'b0;
                rd_en   = 1'b0;
            end
            if (ack_vld) begin
                seen     = 1'b1;
                got_err  = err;
                got_data = rd_data;
            end
        end
        if (!seen) begin
            $display("%s: no ack_vld within %0d cycles for address %h", cur_test, ACK_WAIT, a);
            check_fails++;
        end else begin
            check_latency(is_wr ? "write" : "read", exp_lat, n);
        end
    endtask

    task automatic write_reg(input addr_t a, input data_t d, input logic ns,
                             input int lat, input logic exp_err);
        logic   e;
        data_t  r;
        bus_access(a, 1'b1, d, ns, lat, e, r);
        check_err("write", exp_err, e);
    endtask

    task automatic read_reg(input addr_t a, input logic ns, input int lat,
                            input logic exp_err, input data_t exp_data);
        logic   e;
        data_t  r;
        bus_access(a, 1'b0, '0, ns, lat, e, r);
        check_err("read", exp_err, e);
        check_data("rd_data", exp_data, r);
    endtask

    task automatic soft_reset_pulse(input int cycles);
        @(posedge regdisp_disp_map_clk);
        #(DRIVE_DLY);
        soft_rst = 1'b1;
        repeat (cycles) @(posedge regdisp_disp_map_clk);
        #(DRIVE_DLY);
        soft_rst = 1'b0;
    endtask

    task automatic test_scratch();
        data_t v0;
        data_t v1;
        begin_test("scratch");
        v0 = next_rand();
        v1 = next_rand();
        // registers come out of reset cleared
        read_reg(win_addr(`REGSLV_OFS_SCRATCH0), 1'b0, LAT_MAPPED, 1'b0, '0);
        write_reg(win_addr(`REGSLV_OFS_SCRATCH0), v0, 1'b0, LAT_MAPPED, 1'b0);
        write_reg(win_addr(`REGSLV_OFS_SCRATCH1), v1, 1'b0, LAT_MAPPED, 1'b0);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH0), 1'b0, LAT_MAPPED, 1'b0, v0);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH1), 1'b0, LAT_MAPPED, 1'b0, v1);
        end_test();
    endtask

    task automatic test_dummy();
        data_t keep;
        addr_t win_end;
        begin_test("dummy");
        keep    = next_rand();
        win_end = `REGDISP_BASE_ADDR + `REGDISP_WIN_SIZE;
        write_reg(win_addr(`REGSLV_OFS_SCRATCH0), keep, 1'b0, LAT_MAPPED, 1'b0);
        // address zero has scratch0's offset but lies below the window
        write_reg(addr_t'(0), ~keep, 1'b0, LAT_DUMMY, 1'b0);
        write_reg(win_end, ~keep, 1'b0, LAT_DUMMY, 1'b0);
        read_reg(`REGDISP_BASE_ADDR - addr_t'(4), 1'b0, LAT_DUMMY, 1'b0, '0);
        read_reg(win_end, 1'b0, LAT_DUMMY, 1'b0, '0);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH0), 1'b0, LAT_MAPPED, 1'b0, keep);
        end_test();
    endtask

    task automatic test_secure();
        data_t v;
        addr_t a;
        begin_test("secure");
        v = next_rand();
        a = win_addr(`REGSLV_OFS_SECURE);
        write_reg(a, v, 1'b0, LAT_MAPPED, 1'b0);
        read_reg(a, 1'b0, LAT_MAPPED, 1'b0, v);
        write_reg(a, ~v, 1'b1, LAT_MAPPED, 1'b1);
        read_reg(a, 1'b1, LAT_MAPPED, 1'b1, '0);
        read_reg(a, 1'b0, LAT_MAPPED, 1'b0, v);
        end_test();
    endtask

    task automatic test_id_holes();
        begin_test("id_holes");
        read_reg(win_addr(`REGSLV_OFS_ID), 1'b0, LAT_MAPPED, 1'b0, `REGSLV_ID_VALUE);
        write_reg(win_addr(`REGSLV_OFS_ID), next_rand(), 1'b0, LAT_MAPPED, 1'b1);
        read_reg(win_addr(13'h100), 1'b0, LAT_MAPPED, 1'b1, '0);
        end_test();
    endtask

    task automatic test_soft_reset();
        begin_test("soft_reset");
        write_reg(win_addr(`REGSLV_OFS_SCRATCH0), next_rand() | 32'd1, 1'b0, LAT_MAPPED, 1'b0);
        write_reg(win_addr(`REGSLV_OFS_SCRATCH1), next_rand() | 32'd1, 1'b0, LAT_MAPPED, 1'b0);
        write_reg(win_addr(`REGSLV_OFS_SECURE), next_rand() | 32'd1, 1'b0, LAT_MAPPED, 1'b0);
        soft_reset_pulse(2);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH0), 1'b0, LAT_MAPPED, 1'b0, '0);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH1), 1'b0, LAT_MAPPED, 1'b0, '0);
        read_reg(win_addr(`REGSLV_OFS_SECURE), 1'b0, LAT_MAPPED, 1'b0, '0);
        end_test();
    endtask

    task automatic test_addr_conv();
        data_t v;
        addr_t alias_addr;
        begin_test("addr_conv");
        v          = next_rand();
        // same 13-bit offset as scratch1, but past the window end
        alias_addr = `REGDISP_BASE_ADDR + 48'h2000 + addr_t'(`REGSLV_OFS_SCRATCH1);
        write_reg(win_addr(`REGSLV_OFS_SCRATCH1), v, 1'b0, LAT_MAPPED, 1'b0);
        write_reg(alias_addr, ~v, 1'b0, LAT_DUMMY, 1'b0);
        read_reg(alias_addr, 1'b0, LAT_DUMMY, 1'b0, '0);
        read_reg(win_addr(`REGSLV_OFS_SCRATCH1), 1'b0, LAT_MAPPED, 1'b0, v);
        end_test();
    endtask

    initial begin
        regdisp_disp_map_clk   = 1'b0;
        regdisp_disp_map_rst_n = 1'b0;
        req_vld                = 1'b0;
        addr                   = '0;
        wr_en                  = 1'b0;
        rd_en                  = 1'b0;
        wr_data                = '0;
        non_sec                = 1'b0;
        soft_rst               = 1'b0;
        lcg_state              = 32'd12;
        check_fails            = 0;
        test_fails             = 0;
        fails_at_start         = 0;
        cur_test               = "reset";
        repeat (RESET_CYCLES) @(posedge regdisp_disp_map_clk);
        #(DRIVE_DLY);
        regdisp_disp_map_rst_n = 1'b1;
        test_scratch();
        test_dummy();
        test_secure();
        test_id_holes();
        test_soft_reset();
        test_addr_conv();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 NUM_TESTS, test_fails, check_fails);
        if (check_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* bench/regdisp_chk.sv */
module regdisp_chk (
    input  logic    regdisp_disp_map_clk,
    input  logic    regdisp_disp_map_rst_n,
    input  logic    req_vld,
    input  logic    wr_en,
    input  logic    rd_en,
    input  logic    ack_vld,
    input  logic    err
);
    timeunit 1ns;
    timeprecision 1ps;

    a_err_needs_ack: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) err |-> ack_vld)
        else $error("err high outside an ack_vld cycle");

    a_one_command: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n) req_vld |-> (wr_en ^ rd_en))
        else $error("req_vld without exactly one of wr_en and rd_en");

    // looking back from three cycles later, an ack must have been seen
    a_req_gets_ack: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n)
        $past(req_vld, 3) |-> (ack_vld || $past(ack_vld) || $past(ack_vld, 2)))
        else $error("req_vld not answered by ack_vld within 3 cycles");

    a_ack_has_req: assert property (@(posedge regdisp_disp_map_clk)
        disable iff (!regdisp_disp_map_rst_n)
        ack_vld |-> ($past(req_vld) || $past(req_vld, 2) || $past(req_vld, 3)))
        else $error("ack_vld with no req_vld in the previous 3 cycles");

endmodule

bind regdisp_top regdisp_chk regdisp_chk_inst (
    .regdisp_disp_map_clk   (regdisp_disp_map_clk),
    .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
    .req_vld                (req_vld),
    .wr_en                  (wr_en),
    .rd_en                  (rd_en),
    .ack_vld                (ack_vld),
    .err                    (err)
);

/* logic/regdisp_top.sv */
module regdisp_top
    import regdisp_pkg::*;
(
    input  logic    regdisp_disp_map_clk,
    input  logic    regdisp_disp_map_rst_n,

    input  logic    req_vld,
    input  addr_t   addr,
    input  logic    wr_en,
    input  logic    rd_en,
    input  data_t   wr_data,
    input  logic    non_sec,
    input  logic    soft_rst,
    output logic    ack_vld,
    output logic    err,
    output data_t   rd_data
);

    logic   slv_req_vld;
    addr_t  slv_addr;
    logic   slv_wr_en;
    logic   slv_rd_en;
    data_t  slv_wr_data;
    logic   slv_non_sec;
    logic   slv_soft_rst;
    logic   slv_ack_vld;
    logic   slv_err;
    data_t  slv_rd_data;

    regdisp_disp_map regdisp_disp_map_inst (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .req_vld                (req_vld),
        .addr                   (addr),
        .wr_en                  (wr_en),
        .rd_en                  (rd_en),
        .wr_data                (wr_data),
        .non_sec                (non_sec),
        .soft_rst               (soft_rst),
        .ack_vld                (ack_vld),
        .err                    (err),
        .rd_data                (rd_data),
        .slv_req_vld            (slv_req_vld),
        .slv_addr               (slv_addr),
        .slv_wr_en              (slv_wr_en),
        .slv_rd_en              (slv_rd_en),
        .slv_wr_data            (slv_wr_data),
        .slv_non_sec            (slv_non_sec),
        .slv_soft_rst           (slv_soft_rst),
        .slv_ack_vld            (slv_ack_vld),
        .slv_err                (slv_err),
        .slv_rd_data            (slv_rd_data)
    );

    regslv_slv_map regslv_slv_map_inst (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .slv_req_vld            (slv_req_vld),
        .slv_addr               (slv_addr),
        .slv_wr_en              (slv_wr_en),
        .slv_rd_en              (slv_rd_en),
        .slv_wr_data            (slv_wr_data),
        .slv_non_sec            (slv_non_sec),
        .slv_soft_rst           (slv_soft_rst),
        .slv_ack_vld            (slv_ack_vld),
        .slv_err                (slv_err),
        .slv_rd_data            (slv_rd_data)
    );

endmodule

/* logic/regslv_slv_map.sv */
`include "regdisp_params.svh"

module regslv_slv_map
    import regdisp_pkg::*;
(
    input  logic    regdisp_disp_map_clk,
    input  logic    regdisp_disp_map_rst_n,

    input  logic    slv_req_vld,
    input  addr_t   slv_addr,
    input  logic    slv_wr_en,
    input  logic    slv_rd_en,
    input  data_t   slv_wr_data,
    input  logic    slv_non_sec,
    input  logic    slv_soft_rst,
    output logic    slv_ack_vld,
    output logic    slv_err,
    output data_t   slv_rd_data
);

    localparam int ADDR_W = `REGDISP_ADDR_W;
    localparam int OFS_W  = `REGDISP_OFS_W;

    ofs_t   ofs;
    logic   ofs_in_range;
    data_t  scratch0;
    data_t  scratch1;
    data_t  secure;
    logic   rsp_err;
    data_t  rsp_data;
    logic   wr_scratch0;
    logic   wr_scratch1;
    logic   wr_secure;

    assign ofs = slv_addr[OFS_W-1:0];

    // dispatcher zero-extends, so any high bit means a bad offset
    assign ofs_in_range = ~|slv_addr[ADDR_W-1:OFS_W];

    // access check and read mux
    always_comb begin
        rsp_err     = 1'b0;
        rsp_data    = '0;
        wr_scratch0 = 1'b0;
        wr_scratch1 = 1'b0;
        wr_secure   = 1'b0;
        if (!ofs_in_range) begin
            rsp_err = 1'b1;
        end else begin
            case (ofs)
                `REGSLV_OFS_SCRATCH0: begin
                    rsp_data    = scratch0;
                    wr_scratch0 = slv_req_vld & slv_wr_en;
                end
                `REGSLV_OFS_SCRATCH1: begin
                    rsp_data    = scratch1;
                    wr_scratch1 = slv_req_vld & slv_wr_en;
                end
                `REGSLV_OFS_SECURE: begin
                    // secure-only, non-secure side gets err and nothing else
                    if (slv_non_sec) begin
                        rsp_err = 1'b1;
                    end else begin
                        rsp_data  = secure;
                        wr_secure = slv_req_vld & slv_wr_en;
                    end
                end
                `REGSLV_OFS_ID: begin
                    if (slv_wr_en) begin
                        rsp_err = 1'b1;
                    end else begin
                        rsp_data = `REGSLV_ID_VALUE;
                    end
                end
                default: begin
                    rsp_err = 1'b1;
                end
            endcase
        end
    end

    // storage, held clear while soft reset is asserted
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            scratch0 <= '0;
            scratch1 <= '0;
            secure   <= '0;
        end else if (slv_soft_rst) begin
            scratch0 <= '0;
            scratch1 <= '0;
            secure   <= '0;
        end else begin
            if (wr_scratch0) begin
                scratch0 <= slv_wr_data;
            end
            if (wr_scratch1) begin
                scratch1 <= slv_wr_data;
            end
            if (wr_secure) begin
                secure <= slv_wr_data;
            end
        end
    end

    // every request is answered on the next cycle
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            slv_ack_vld <= 1'b0;
            slv_err     <= 1'b0;
        end else begin
            slv_ack_vld <= slv_req_vld;
            slv_err     <= slv_req_vld & rsp_err;
        end
    end

    // read data only for a successful read
    always_ff @(posedge regdisp_disp_map_clk) begin
        slv_rd_data <= (slv_req_vld && slv_rd_en && !rsp_err) ? rsp_data : '0;
    end

endmodule

/* logic/regdisp_disp_map.sv */
`include "regdisp_params.svh"

module regdisp_disp_map
    import regdisp_pkg::*;
(
    input  logic    regdisp_disp_map_clk,
    input  logic    regdisp_disp_map_rst_n,

    // upstream bus
    input  logic    req_vld,
    input  addr_t   addr,
    input  logic    wr_en,
    input  logic    rd_en,
    input  data_t   wr_data,
    input  logic    non_sec,
    input  logic    soft_rst,
    output logic    ack_vld,
    output logic    err,
    output data_t   rd_data,

    // link to the register slave
    output logic    slv_req_vld,
    output addr_t   slv_addr,
    output logic    slv_wr_en,
    output logic    slv_rd_en,
    output data_t   slv_wr_data,
    output logic    slv_non_sec,
    output logic    slv_soft_rst,
    input  logic    slv_ack_vld,
    input  logic    slv_err,
    input  data_t   slv_rd_data
);

    localparam int    ADDR_W    = `REGDISP_ADDR_W;
    localparam int    OFS_W     = `REGDISP_OFS_W;
    localparam int    BYTE_BITS = $clog2(`REGDISP_DATA_W / 8);
    localparam addr_t WIN_LO    = addr_t'(`REGDISP_BASE_ADDR);
    localparam addr_t WIN_HI    = addr_t'(`REGDISP_BASE_ADDR + `REGDISP_WIN_SIZE);

    logic [ADDR_W-BYTE_BITS-1:0]    word_addr;
    logic                           win_hit;
    logic                           dec_child_sel;
    logic                           dec_dummy_sel;
    logic                           dummy_ack_vld;
    ofs_t                           ofs;
    fwd_req_t                       fwd_imux;
    fwd_req_t                       fwd_out;
    logic                           bwd_ack_mux;
    bwd_rsp_t                       bwd_mux;
    bwd_rsp_t                       bwd_out;

    // decode on word address, the byte lane bits do not matter
    assign word_addr = addr[ADDR_W-1:BYTE_BITS];
    assign win_hit   = (word_addr >= WIN_LO[ADDR_W-1:BYTE_BITS]) &&
                       (word_addr <  WIN_HI[ADDR_W-1:BYTE_BITS]);

    assign dec_child_sel = req_vld & win_hit;
    assign dec_dummy_sel = req_vld & ~win_hit;

    // child sees only its own offset
    assign ofs = addr[OFS_W-1:0];

    // inverse mux towards the single child
    always_comb begin
        fwd_imux          = '0;
        fwd_imux.soft_rst = soft_rst;
        if (dec_child_sel) begin
            fwd_imux.addr    = addr_t'(ofs);
            fwd_imux.wr_en   = wr_en;
            fwd_imux.rd_en   = rd_en;
            fwd_imux.wr_data = wr_data;
            fwd_imux.non_sec = non_sec;
        end
    end

    regdisp_pipe_slice #(
        .payload_t  (fwd_req_t),
        .ENABLE     (`REGDISP_FWD_FF)
    ) fwd_slice_inst (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .in_vld                 (dec_child_sel),
        .in_data                (fwd_imux),
        .out_vld                (slv_req_vld),
        .out_data               (fwd_out)
    );

    assign slv_addr     = fwd_out.addr;
    assign slv_wr_en    = fwd_out.wr_en;
    assign slv_rd_en    = fwd_out.rd_en;
    assign slv_wr_data  = fwd_out.wr_data;
    assign slv_non_sec  = fwd_out.non_sec;
    assign slv_soft_rst = fwd_out.soft_rst;

    // dummy register answers out-of-window requests one cycle later
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            dummy_ack_vld <= 1'b0;
        end else begin
            dummy_ack_vld <= dec_dummy_sel;
        end
    end

    // backward mux, dummy never reports err and reads as zero
    assign bwd_ack_mux = slv_ack_vld | dummy_ack_vld;

    always_comb begin
        bwd_mux.err     = slv_ack_vld & slv_err;
        bwd_mux.rd_data = '0;
        if (!dummy_ack_vld && slv_ack_vld) begin
            bwd_mux.rd_data = slv_rd_data;
        end
    end

    regdisp_pipe_slice #(
        .payload_t  (bwd_rsp_t),
        .ENABLE     (`REGDISP_BWD_FF)
    ) bwd_slice_inst (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .in_vld                 (bwd_ack_mux),
        .in_data                (bwd_mux),
        .out_vld                (ack_vld),
        .out_data               (bwd_out)
    );

    assign err     = bwd_out.err;
    assign rd_data = bwd_out.rd_data;

endmodule

/* logic/regdisp_pipe_slice.sv */
module regdisp_pipe_slice #(
    parameter type payload_t = logic,
    parameter int  ENABLE    = 1
) (
    input  logic        regdisp_disp_map_clk,
    input  logic        regdisp_disp_map_rst_n,
    input  logic        in_vld,
    input  payload_t    in_data,
    output logic        out_vld,
    output payload_t    out_data
);

    if (ENABLE != 0) begin : g_ff
        // one cycle of delay on valid and payload alike
        always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
            if (!regdisp_disp_map_rst_n) begin
                out_vld  <= 1'b0;
                out_data <= '0;
            end else begin
                out_vld  <= in_vld;
                // payload follows every cycle so level fields keep tracking
                out_data <= in_data;
            end
        end
    end else begin : g_bypass
        assign out_vld  = in_vld;
        assign out_data = in_data;
    end

endmodule

/* logic/regdisp_pkg.sv */
`include "regdisp_params.svh"

package regdisp_pkg;

    // absolute address as seen on the upstream bus
    typedef logic [`REGDISP_ADDR_W-1:0] addr_t;

    typedef logic [`REGDISP_DATA_W-1:0] data_t;

    // offset kept after the window base is stripped
    typedef logic [`REGDISP_OFS_W-1:0]  ofs_t;

    // request as it travels from dispatcher to slave
    typedef struct packed {
        addr_t  addr;
        logic   wr_en;
        logic   rd_en;
        data_t  wr_data;
        logic   non_sec;
        // level signal, passed on whether or not the child is selected
        logic   soft_rst;
    } fwd_req_t;

    // response after the backward mux
    typedef struct packed {
        logic   err;
        data_t  rd_data;
    } bwd_rsp_t;

endpackage

/* logic/regdisp_params.svh */
`ifndef REGDISP_PARAMS_SVH
`define REGDISP_PARAMS_SVH

// bus widths
`define REGDISP_ADDR_W          48
`define REGDISP_DATA_W          32

// child window in absolute byte addresses
`define REGDISP_BASE_ADDR       48'h0000_0000_4000
`define REGDISP_WIN_SIZE        48'h0000_0000_10c8

// offset bits the slave keeps
`define REGDISP_OFS_W           13

// slave register map, offsets inside the window
`define REGSLV_OFS_SCRATCH0     13'h0000
`define REGSLV_OFS_SCRATCH1     13'h0004
`define REGSLV_OFS_SECURE       13'h0008
`define REGSLV_OFS_ID           13'h10c4
`define REGSLV_ID_VALUE         32'h5244_0001

// 1 inserts the register stage, 0 bypasses it
`define REGDISP_FWD_FF          1
`define REGDISP_BWD_FF          1

`endif
